//--- design/bridge_cmd_pkg.sv
// Frame level protocol seen by the SPI controller
// A frame is a run of bytes between a falling and a rising chip select
package bridge_cmd_pkg;

    // Opcode in the first byte of a frame
    // Values not listed here decode as a no-op
    typedef enum logic [7:0] {
        CMD_READ  = 8'h01,  // cmd, addr, turnaround, tail
        CMD_WRITE = 8'h02   // cmd, addr, data
    } cmd_op_e;

    // Position of the byte now being shifted in
    typedef enum logic [1:0] {
        POS_CMD  = 2'd0,    // Opcode byte
        POS_ADDR = 2'd1,    // Register address
        POS_DATA = 2'd2,    // Write data, or turnaround on a read
        POS_TAIL = 2'd3     // Read data goes out here, saturates
    } frame_pos_e;

    // Returned on every byte that carries no read data
    localparam logic [7:0] FILLER_BYTE = 8'h00;

endpackage

//--- design/wb_bus_pkg.sv
// Definitions for the internal Wishbone side of the bridge
package wb_bus_pkg;

    // Request kind handed from the frame decoder to the bus master
    typedef enum logic {
        WB_OP_READ  = 1'b0,
        WB_OP_WRITE = 1'b1
    } wb_op_e;

    // Registers behind the slave, one per address
    localparam int REG_COUNT = 8;

endpackage

//--- design/spi_shift.sv
`timescale 1ns/1ps

// SPI mode 0 shift core, oversampled on the system clock
// SDI sampled on SCK rise, SDO changes on SCK fall, MSB first
module spi_shift
    import bridge_cmd_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  spi_cs_ni,     // System clock
    input  logic                  spi_sck_i,     // Async reset, active high
    input  logic                  ser_cs_ni,     // SPI chip select pin
    input  logic                  ser_sck_i,     // SPI clock pin
    input  logic                  ser_sdi_i,     // SPI data in pin
    output logic                  ser_sdo_o,     // SPI data out pin
    input  logic [DATA_WIDTH-1:0] tx_byte_i,     // Next byte to send
    output logic [DATA_WIDTH-1:0] rx_byte_o,     // Last byte received
    output logic                  byte_valid_o,  // One cycle, rx_byte_o is new
    output logic                  frame_end_o    // One cycle after CS rises
);
    localparam int CNT_W = $clog2(DATA_WIDTH);

    logic [1:0]            cs_sync, sck_sync, sdi_sync;  // Two-flop pin synchronizers
    logic                  cs_s, sck_s, sdi_s;
    logic                  cs_q, sck_q;                  // Previous synced level
    logic                  sck_rise, sck_fall, cs_fall, cs_rise;
    logic [CNT_W-1:0]      bit_cnt;                      // Rises seen in current byte
    logic                  byte_done;                    // Last bit just shifted in
    logic                  load_q;                       // Reload tx one cycle after strobe
    logic [DATA_WIDTH-1:0] rx_sr;
    logic [DATA_WIDTH-1:0] tx_sr;

    assign cs_s  = cs_sync[1];
    assign sck_s = sck_sync[1];
    assign sdi_s = sdi_sync[1];

    // Edge detect on synced levels, third clock of the pin latency
    assign sck_rise = sck_s & ~sck_q;
    assign sck_fall = ~sck_s & sck_q;
    assign cs_fall  = ~cs_s & cs_q;
    assign cs_rise  = cs_s & ~cs_q;

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            cs_sync      <= 2'b11;  // Deselected
            sck_sync     <= 2'b00;  // Mode 0 idles low
            sdi_sync     <= 2'b00;
            cs_q         <= 1'b1;
            sck_q        <= 1'b0;
            bit_cnt      <= '0;
            byte_done    <= 1'b0;
            byte_valid_o <= 1'b0;
            load_q       <= 1'b0;
            frame_end_o  <= 1'b0;
        end else begin
            cs_sync   <= {cs_sync[0], ser_cs_ni};
            sck_sync  <= {sck_sync[0], ser_sck_i};
            sdi_sync  <= {sdi_sync[0], ser_sdi_i};
            cs_q      <= cs_s;
            sck_q     <= sck_s;
            byte_done <= 1'b0;
            if (cs_s) begin
                bit_cnt <= '0;  // Realign at every frame
            end else if (sck_rise) begin
                if (bit_cnt == CNT_W'(DATA_WIDTH - 1)) begin
                    bit_cnt   <= '0;
                    byte_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
            byte_valid_o <= byte_done;  // Fourth clock after the 8th rise
            load_q       <= byte_valid_o;
            frame_end_o  <= cs_rise;
        end
    end

    // Receive path
    always_ff @(posedge spi_cs_ni) begin
        if (sck_rise && !cs_s) rx_sr <= {rx_sr[DATA_WIDTH-2:0], sdi_s};
        if (byte_done) rx_byte_o <= rx_sr;  // Held until the next byte completes
    end

    // Transmit path
    // No shift on the fall after the last bit, the reload puts the next MSB out
    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            tx_sr <= DATA_WIDTH'(FILLER_BYTE);
        end else if (cs_fall || load_q) begin
            tx_sr <= tx_byte_i;
        end else if (sck_fall && !cs_s && bit_cnt != '0) begin
            tx_sr <= {tx_sr[DATA_WIDTH-2:0], 1'b0};
        end
    end

    assign ser_sdo_o = tx_sr[DATA_WIDTH-1];

    // Strobe must come from a selected frame, CS timing is on the controller
    a_no_byte_when_idle: assert property (
        @(posedge spi_cs_ni) disable iff (spi_sck_i) byte_valid_o |-> !cs_s
    );

endmodule

//--- design/frame_decode.sv
`timescale 1ns/1ps

// Frame decoder
// Walks command, address and data bytes and issues at most one bus request per frame
module frame_decode
    import bridge_cmd_pkg::*;
    import wb_bus_pkg::*;
#(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 3
) (
    input  logic                  spi_cs_ni,    // System clock
    input  logic                  spi_sck_i,    // Async reset, active high
    input  logic [DATA_WIDTH-1:0] rx_byte_i,
    input  logic                  byte_valid_i,
    input  logic                  frame_end_i,
    output logic                  req_o,        // One cycle request pulse
    output wb_op_e                req_op_o,
    output logic [ADDR_WIDTH-1:0] req_addr_o,
    output logic [DATA_WIDTH-1:0] req_wdata_o,
    output frame_pos_e            frame_pos_o   // Byte now on the wire
);
    frame_pos_e pos_q;
    cmd_op_e    op_q;  // Opcode of the current frame

    assign frame_pos_o = pos_q;

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            pos_q    <= POS_CMD;
            op_q     <= cmd_op_e'(8'h00);  // No-op
            req_o    <= 1'b0;
            req_op_o <= WB_OP_READ;
        end else begin
            req_o <= 1'b0;
            if (frame_end_i) begin
                pos_q <= POS_CMD;  // Early end drops whatever is pending
            end else if (byte_valid_i) begin
                case (pos_q)
                    POS_CMD: begin
                        op_q  <= cmd_op_e'(rx_byte_i[7:0]);
                        pos_q <= POS_ADDR;
                    end
                    POS_ADDR: begin
                        pos_q <= POS_DATA;
                        // Read goes out now so data is back before the tail
                        if (op_q == CMD_READ) begin
                            req_o    <= 1'b1;
                            req_op_o <= WB_OP_READ;
                        end
                    end
                    POS_DATA: begin
                        pos_q <= POS_TAIL;
                        // Write only once the data byte is complete
                        if (op_q == CMD_WRITE) begin
                            req_o    <= 1'b1;
                            req_op_o <= WB_OP_WRITE;
                        end
                    end
                    default: pos_q <= POS_TAIL;  // Extra bytes ignored
                endcase
            end
        end
    end

    // Request payload, valid with req_o
    always_ff @(posedge spi_cs_ni) begin
        if (byte_valid_i && pos_q == POS_ADDR) begin
            req_addr_o <= rx_byte_i[ADDR_WIDTH-1:0];  // Upper address bits dropped
        end
        if (byte_valid_i && pos_q == POS_DATA) begin
            req_wdata_o <= rx_byte_i;
        end
    end

endmodule

//--- design/wb_exec.sv
`timescale 1ns/1ps

// Wishbone classic master
// One request at a time, bus held until ack
module wb_exec
    import wb_bus_pkg::*;
#(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 3
) (
    input  logic                  spi_cs_ni,   // System clock
    input  logic                  spi_sck_i,   // Async reset, active high
    input  logic                  req_i,
    input  wb_op_e                req_op_i,
    input  logic [ADDR_WIDTH-1:0] req_addr_i,
    input  logic [DATA_WIDTH-1:0] req_wdata_i,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output logic                  wb_we_o,
    output logic [ADDR_WIDTH-1:0] wb_adr_o,
    output logic [DATA_WIDTH-1:0] wb_dat_o,
    input  logic                  wb_ack_i,
    input  logic [DATA_WIDTH-1:0] wb_dat_i,
    output logic                  rd_valid_o,  // One cycle pulse when read data is captured
    output logic [DATA_WIDTH-1:0] rd_data_o
);
    logic start;
    logic done;

    assign start = req_i && !wb_cyc_o;
    assign done  = wb_cyc_o && wb_ack_i;

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            wb_cyc_o   <= 1'b0;
            wb_stb_o   <= 1'b0;
            wb_we_o    <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= 1'b0;
            if (done) begin
                wb_cyc_o   <= 1'b0;      // Cycle ends the clock after ack
                wb_stb_o   <= 1'b0;
                wb_we_o    <= 1'b0;
                rd_valid_o <= !wb_we_o;  // Only reads report back
            end else if (start) begin
                wb_cyc_o <= 1'b1;
                wb_stb_o <= 1'b1;
                wb_we_o  <= (req_op_i == WB_OP_WRITE);
            end
        end
    end

    // Address and data held for the whole cycle
    always_ff @(posedge spi_cs_ni) begin
        if (start) begin
            wb_adr_o <= req_addr_i;
            wb_dat_o <= req_wdata_i;
        end
        if (done && !wb_we_o) rd_data_o <= wb_dat_i;
    end

    // Decoder spaces requests a full byte apart, so a busy bus means a lost request
    a_no_req_when_busy: assert property (
        @(posedge spi_cs_ni) disable iff (spi_sck_i) req_i |-> !wb_cyc_o
    );

    // Slave must not ack outside a strobe
    a_ack_in_strobe: assert property (
        @(posedge spi_cs_ni) disable iff (spi_sck_i) wb_ack_i |-> wb_stb_o
    );

endmodule

//--- design/result_load.sv
`timescale 1ns/1ps

// Result stage
// Picks the byte the shift core loads next
module result_load
    import bridge_cmd_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  spi_cs_ni,    // System clock
    input  logic                  spi_sck_i,    // Async reset, active high
    input  logic                  rd_valid_i,   // Read data from the bus master
    input  logic [DATA_WIDTH-1:0] rd_data_i,
    input  frame_pos_e            frame_pos_i,  // Position of the next byte to load
    input  logic                  frame_end_i,
    output logic [DATA_WIDTH-1:0] tx_byte_o
);
    localparam logic [DATA_WIDTH-1:0] FILL = DATA_WIDTH'(FILLER_BYTE);

    logic [DATA_WIDTH-1:0] rd_q;  // Last read value of this frame

    // Read ack arrives during the turnaround byte, well before the tail load
    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            rd_q <= FILL;
        end else if (frame_end_i) begin
            rd_q <= FILL;       // Nothing carries over into the next frame
        end else if (rd_valid_i) begin
            rd_q <= rd_data_i;
        end
    end

    // Tail gets the read value, every other byte the filler
    // Frames without a read still show FILL here since rd_q was cleared
    assign tx_byte_o = (frame_pos_i == POS_TAIL) ? rd_q : FILL;

endmodule

//--- design/reg_file_wb.sv
`timescale 1ns/1ps

// Wishbone classic slave with REG_COUNT registers
// Ack one clock after strobe, never held two cycles
module reg_file_wb
    import wb_bus_pkg::*;
#(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 3
) (
    input  logic                  spi_cs_ni,  // System clock
    input  logic                  spi_sck_i,  // Async reset, active high
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [ADDR_WIDTH-1:0] wb_adr_i,
    input  logic [DATA_WIDTH-1:0] wb_dat_i,
    output logic                  wb_ack_o,
    output logic [DATA_WIDTH-1:0] wb_dat_o
);
    logic [DATA_WIDTH-1:0] regs [REG_COUNT];
    logic                  access;  // First cycle of a strobe

    assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            wb_ack_o <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            wb_ack_o <= access;  // Drops again while master releases stb
            if (access && wb_we_i) regs[wb_adr_i] <= wb_dat_i;  // Lands with the ack
        end
    end

    // Read data registered alongside the ack
    always_ff @(posedge spi_cs_ni) begin
        if (access && !wb_we_i) wb_dat_o <= regs[wb_adr_i];
    end

endmodule

//--- design/spi_wb_bridge.sv
`timescale 1ns/1ps

// SPI peripheral to internal Wishbone register file
// shift core -> decode -> execute -> slave, read data back via result stage
module spi_wb_bridge
    import bridge_cmd_pkg::*;
    import wb_bus_pkg::*;
#(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 3
) (
    input  logic spi_cs_ni,  // System clock
    input  logic spi_sck_i,  // Async reset, active high
    input  logic ser_cs_ni,
    input  logic ser_sck_i,
    input  logic ser_sdi_i,
    output logic ser_sdo_o
);
    logic [DATA_WIDTH-1:0] rx_byte, tx_byte;
    logic                  byte_valid, frame_end;
    logic                  req;
    wb_op_e                req_op;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic [DATA_WIDTH-1:0] req_wdata;
    frame_pos_e            frame_pos;
    logic                  wb_cyc, wb_stb, wb_we, wb_ack;
    logic [ADDR_WIDTH-1:0] wb_adr;
    logic [DATA_WIDTH-1:0] wb_dat_w, wb_dat_r;  // Master to slave, slave to master
    logic                  rd_valid;
    logic [DATA_WIDTH-1:0] rd_data;

    spi_shift #(.DATA_WIDTH(DATA_WIDTH)) u_shift (
        .spi_cs_ni, .spi_sck_i, .ser_cs_ni, .ser_sck_i, .ser_sdi_i, .ser_sdo_o,
        .tx_byte_i(tx_byte), .rx_byte_o(rx_byte),
        .byte_valid_o(byte_valid), .frame_end_o(frame_end)
    );

    frame_decode #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_decode (
        .spi_cs_ni, .spi_sck_i,
        .rx_byte_i(rx_byte), .byte_valid_i(byte_valid), .frame_end_i(frame_end),
        .req_o(req), .req_op_o(req_op), .req_addr_o(req_addr),
        .req_wdata_o(req_wdata), .frame_pos_o(frame_pos)
    );

    wb_exec #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_exec (
        .spi_cs_ni, .spi_sck_i,
        .req_i(req), .req_op_i(req_op), .req_addr_i(req_addr), .req_wdata_i(req_wdata),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we),
        .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w),
        .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_r),
        .rd_valid_o(rd_valid), .rd_data_o(rd_data)
    );

    result_load #(.DATA_WIDTH(DATA_WIDTH)) u_result (
        .spi_cs_ni, .spi_sck_i,
        .rd_valid_i(rd_valid), .rd_data_i(rd_data),
        .frame_pos_i(frame_pos), .frame_end_i(frame_end),
        .tx_byte_o(tx_byte)
    );

    reg_file_wb #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_regs (
        .spi_cs_ni, .spi_sck_i,
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r)
    );

endmodule

//--- testbench/spi_host_tasks.svh
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// SPI mode 0 controller for the bridge testbench
// Pins change 2 ns after a rising system clock, SCK half period 5 clocks

// Wait n clocks, then move off the edge
task automatic step(input int n);
    repeat (n) @(posedge sys_clk);
    #2;
endtask

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

// One LFSR step per bit taken
task automatic rand_byte(output logic [7:0] b);
    int i;
    for (i = 0; i < 8; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        b = {b[6:0], lfsr_q[0]};
    end
endtask

// Shift one byte MSB first and hand the received byte to the checker
task automatic xfer_byte(input logic [7:0] tx, input logic [7:0] exp);
    logic [7:0] rx;
    int i;
    for (i = 7; i >= 0; i--) begin
        ser_sdi_i = tx[i];  // Set while SCK is low
        step(5);
        rx[i] = ser_sdo_o;  // Settled long before the rising edge
        ser_sck_i = 1'b1;
        step(5);
        ser_sck_i = 1'b0;
    end
    rx_got   = rx;
    rx_exp   = exp;
    rx_check = 1'b1;
    checks++;
    step(1);
    rx_check = 1'b0;
endtask

task automatic frame_open();
    ser_cs_ni = 1'b0;
    step(5);  // Shift core loads its first byte meanwhile
endtask

task automatic frame_close();
    step(5);
    ser_cs_ni = 1'b1;
    step(10);  // Gap between frames
endtask

// Command, address, data; all three bytes return the filler
task automatic write_frame(input int addr, input logic [7:0] data);
    frame_open();
    xfer_byte(CMD_WRITE, FILLER_BYTE);
    xfer_byte(8'(addr), FILLER_BYTE);
    xfer_byte(data, FILLER_BYTE);
    frame_close();
    model[addr] = data;
endtask

// Command, address, turnaround, tail with the register value
task automatic read_frame(input int addr);
    frame_open();
    xfer_byte(CMD_READ, FILLER_BYTE);
    xfer_byte(8'(addr), FILLER_BYTE);
    xfer_byte(8'h00, FILLER_BYTE);
    xfer_byte(8'h00, model[addr]);
    frame_close();
endtask

// Full length frame with an opcode the bridge does not know
task automatic noop_frame(input logic [7:0] op, input int addr);
    frame_open();
    xfer_byte(op, FILLER_BYTE);
    xfer_byte(8'(addr), FILLER_BYTE);
    xfer_byte(8'hC3, FILLER_BYTE);
    xfer_byte(8'h3C, FILLER_BYTE);
    frame_close();
endtask

// Write that ends after the address byte, model left as is
task automatic abort_frame(input int addr);
    frame_open();
    xfer_byte(CMD_WRITE, FILLER_BYTE);
    xfer_byte(8'(addr), FILLER_BYTE);
    frame_close();
endtask

`endif

//--- testbench/tb_spi_wb_bridge.sv
`timescale 1ns/1ps

// Testbench for the SPI to Wishbone bridge
// Checking sits in the concurrent assertions below, the sequence only feeds them
module tb_spi_wb_bridge
    import bridge_cmd_pkg::*;
    import wb_bus_pkg::*;
;
    localparam int NUM_FRAMES  = 41;                        // Frames sent by the sequence
    localparam int CYCLE_LIMIT = NUM_FRAMES * 4 * 8 * 10 * 2;  // 4 bytes, 8 bits, 10 clocks, x2

    logic       sys_clk;
    logic       sys_rst;
    logic       ser_cs_ni, ser_sck_i, ser_sdi_i, ser_sdo_o;
    logic [7:0] model [REG_COUNT];  // Expected register contents
    logic [7:0] rx_got, rx_exp;     // Last byte seen on SDO and its expected value
    logic       rx_check;           // One clock, byte ready for comparison
    logic [15:0] lfsr_q;
    string      test_name;
    int         errors, checks, cycles;
    int         a;
    logic [7:0] d;

    `include "spi_host_tasks.svh"

    always #10 sys_clk = ~sys_clk;  // 20 ns period

    spi_wb_bridge #(.DATA_WIDTH(8), .ADDR_WIDTH(3)) dut0 (
        .spi_cs_ni(sys_clk), .spi_sck_i(sys_rst),
        .ser_cs_ni, .ser_sck_i, .ser_sdi_i, .ser_sdo_o
    );

    // Every received byte must match the filler or the model value
    a_rx_byte: assert property (
        @(posedge sys_clk) disable iff (sys_rst) rx_check |-> rx_got == rx_exp
    ) else begin
        errors++;
        $display("** Error [%s] expected 8'h%02h actual 8'h%02h", test_name, rx_exp, rx_got);
    end

    // SDO stays low while the bridge is held in reset
    a_sdo_in_reset: assert property (@(posedge sys_clk) sys_rst |-> !ser_sdo_o)
        else begin
            errors++;
            $display("SDO was driven high while the bridge was in reset");
        end

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        sys_clk = 1'b0;
        sys_rst = 1'b1;
        ser_cs_ni = 1'b1;  // Deselected, SCK idles low in mode 0
        ser_sck_i = 1'b0;
        ser_sdi_i = 1'b0;
        rx_check = 1'b0;
        rx_got = '0;
        rx_exp = '0;
        lfsr_q = 16'd55;
        errors = 0;
        checks = 0;
        cycles = 0;
        test_name = "reset";
        for (a = 0; a < REG_COUNT; a++) model[a] = '0;
        repeat (8) @(posedge sys_clk);
        #2;
        sys_rst = 1'b0;
        step(5);

        test_name = "reset_values";
        for (a = 0; a < REG_COUNT; a++) read_frame(a);

        test_name = "write_all";
        for (a = 0; a < REG_COUNT; a++) begin
            rand_byte(d);
            write_frame(a, d);
        end
        for (a = 0; a < REG_COUNT; a++) read_frame(a);

        test_name = "write_read_back";
        rand_byte(d);
        write_frame(5, d);
        read_frame(5);
        write_frame(5, ~d);  // Differs from the first value in every bit
        read_frame(5);

        test_name = "unknown_opcode";
        noop_frame(8'h5A, 2);
        for (a = 0; a < REG_COUNT; a++) read_frame(a);

        test_name = "aborted_write";
        abort_frame(6);
        read_frame(6);
        rand_byte(d);
        write_frame(6, d);  // Decoder back at the command byte
        read_frame(6);

        step(4);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+testbench
design/bridge_cmd_pkg.sv
design/wb_bus_pkg.sv
design/spi_shift.sv
design/frame_decode.sv
design/wb_exec.sv
design/result_load.sv
design/reg_file_wb.sv
design/spi_wb_bridge.sv
testbench/tb_spi_wb_bridge.sv

//--- Bender.yml
package:
  name: spi_wb_bridge

sources:
  - files:
      - design/bridge_cmd_pkg.sv
      - design/wb_bus_pkg.sv
      - design/spi_shift.sv
      - design/frame_decode.sv
      - design/wb_exec.sv
      - design/result_load.sv
      - design/reg_file_wb.sv
      - design/spi_wb_bridge.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_spi_wb_bridge.sv
